// ==== Makefile ====
TOP   := tb_mem_subsystem
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) \
		-Mdir $(BUILD) -o sim
	-./$(BUILD)/sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// ==== design/axil_master.sv ====
// AXI4-Lite bus master
`timescale 1ns/10ps
`default_nettype none

module axil_master import lsu_pkg::*; (
	input  logic        i_clock,
	input  logic        i_arst_n,

	// Word request from the arbiter
	input  logic        i_req_valid,
	input  word_req_t   i_req,
	output logic        o_rsp_valid,
	output word_rsp_t   o_rsp,

	// Write channels
	output logic        o_awvalid,
	input  logic        i_awready,
	output logic [31:0] o_awaddr,
	output logic        o_wvalid,
	input  logic        i_wready,
	output logic [31:0] o_wdata,
	output logic [3:0]  o_wstrb,
	input  logic        i_bvalid,
	output logic        o_bready,
	input  logic [1:0]  i_bresp,

	// Read channels
	output logic        o_arvalid,
	input  logic        i_arready,
	output logic [31:0] o_araddr,
	input  logic        i_rvalid,
	output logic        o_rready,
	input  logic [31:0] i_rdata,
	input  logic [1:0]  i_rresp
);

	typedef enum logic [1:0] {
		M_IDLE,
		M_WRITE,
		M_READ
	} master_state_e;

	master_state_e state;
	logic new_req;

	assign new_req = i_req_valid && !o_rsp_valid && (state == M_IDLE);

	// Whole words only
	assign o_wstrb = 4'hF;
	assign o_bready = 1'b1;
	assign o_rready = 1'b1;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= M_IDLE;
			o_awvalid <= 1'b0;
			o_wvalid <= 1'b0;
			o_arvalid <= 1'b0;
			o_rsp_valid <= 1'b0;
		end else begin
			o_rsp_valid <= 1'b0;
			case (state)
				M_IDLE: begin
					if (new_req && i_req.write) begin
						o_awvalid <= 1'b1;
						o_wvalid <= 1'b1;
						state <= M_WRITE;
					end else if (new_req) begin
						o_arvalid <= 1'b1;
						state <= M_READ;
					end
				end
				M_WRITE: begin
					// AW and W complete independently
					if (o_awvalid && i_awready)
						o_awvalid <= 1'b0;
					if (o_wvalid && i_wready)
						o_wvalid <= 1'b0;
					if (i_bvalid) begin
						o_rsp_valid <= 1'b1;
						state <= M_IDLE;
					end
				end
				default: begin
					if (o_arvalid && i_arready)
						o_arvalid <= 1'b0;
					if (i_rvalid) begin
						o_rsp_valid <= 1'b1;
						state <= M_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (new_req) begin
			o_awaddr <= i_req.address;
			o_araddr <= i_req.address;
			o_wdata <= i_req.wdata;
		end
		if (state == M_WRITE && i_bvalid) begin
			o_rsp.rdata <= '0;
			o_rsp.error <= |i_bresp;
		end
		if (state == M_READ && i_rvalid) begin
			o_rsp.rdata <= i_rdata;
			o_rsp.error <= |i_rresp;
		end
	end

endmodule

`default_nettype wire

// ==== design/bus_arbiter.sv ====
// Data and fetch bus arbiter
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter import lsu_pkg::*; (
	input  logic        i_clock,
	input  logic        i_arst_n,

	// Data cache
	input  logic        i_data_req_valid,
	input  word_req_t   i_data_req,
	output logic        o_data_rsp_valid,
	output word_rsp_t   o_data_rsp,

	// Instruction fetch
	input  logic        i_fetch_req_valid,
	input  logic [31:0] i_fetch_address,
	output logic        o_fetch_rsp_valid,
	output logic [31:0] o_fetch_rdata,

	// Shared bus
	output logic        o_bus_req_valid,
	output word_req_t   o_bus_req,
	input  logic        i_bus_rsp_valid,
	input  word_rsp_t   i_bus_rsp
);

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_DATA,
		ARB_FETCH
	} arb_state_e;

	arb_state_e state;
	logic last_fetch;
	logic data_wants;
	logic fetch_wants;
	logic pick_fetch;
	word_req_t fetch_req;

	// Requester still holding valid in its response cycle is not a new request
	assign data_wants = i_data_req_valid && !o_data_rsp_valid;
	assign fetch_wants = i_fetch_req_valid && !o_fetch_rsp_valid;
	assign pick_fetch = fetch_wants && (!data_wants || !last_fetch);

	assign fetch_req.write = 1'b0;
	assign fetch_req.flush = 1'b0;
	assign fetch_req.address = {i_fetch_address[31:2], 2'b00};
	assign fetch_req.wdata = '0;

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ARB_IDLE;
			last_fetch <= 1'b0;
			o_bus_req_valid <= 1'b0;
			o_data_rsp_valid <= 1'b0;
			o_fetch_rsp_valid <= 1'b0;
		end else begin
			o_data_rsp_valid <= 1'b0;
			o_fetch_rsp_valid <= 1'b0;
			if (state == ARB_IDLE) begin
				if (data_wants || fetch_wants) begin
					o_bus_req_valid <= 1'b1;
					last_fetch <= pick_fetch;
					state <= pick_fetch ? ARB_FETCH : ARB_DATA;
				end
			end else if (i_bus_rsp_valid) begin
				o_bus_req_valid <= 1'b0;
				o_data_rsp_valid <= (state == ARB_DATA);
				o_fetch_rsp_valid <= (state == ARB_FETCH);
				state <= ARB_IDLE;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == ARB_IDLE)
			o_bus_req <= pick_fetch ? fetch_req : i_data_req;
		if (i_bus_rsp_valid) begin
			o_data_rsp <= i_bus_rsp;
			o_fetch_rdata <= i_bus_rsp.rdata;
		end
	end

endmodule

`default_nettype wire

// ==== design/dcache_wt.sv ====
// Write-through data cache
`timescale 1ns/10ps
`default_nettype none

`include "lsu_cfg.svh"

module dcache_wt import lsu_pkg::*; #(
	parameter int INDEX_BITS = `DCACHE_INDEX_BITS
) (
	input  logic        i_clock,
	input  logic        i_arst_n,

	// Load/store unit side
	input  logic        i_req_valid,
	input  word_req_t   i_req,
	output logic        o_rsp_valid,
	output word_rsp_t   o_rsp,

	// Bus side
	output logic        o_bus_req_valid,
	output word_req_t   o_bus_req,
	input  logic        i_bus_rsp_valid,
	input  word_rsp_t   i_bus_rsp,

	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count
);

	localparam int LINES = 1 << INDEX_BITS;
	localparam int TAG_BITS = 30 - INDEX_BITS;

	typedef enum logic {
		CACHE_IDLE,
		CACHE_BUS
	} cache_state_e;

	cache_state_e state;
	logic [LINES-1:0] valid_bits;
	logic [TAG_BITS-1:0] tags [LINES];
	logic [`DATA_WIDTH-1:0] line_data [LINES];

	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0] tag;
	logic cacheable;
	logic hit;
	logic new_req;

	// Request is held stable until the response, so lookup uses it directly
	assign index = i_req.address[INDEX_BITS+1:2];
	assign tag = i_req.address[31:INDEX_BITS+2];
	assign cacheable = (i_req.address[31:28] == `CACHEABLE_REGION);
	assign hit = cacheable && valid_bits[index] && (tags[index] == tag);
	assign new_req = i_req_valid && !o_rsp_valid && (state == CACHE_IDLE);

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= CACHE_IDLE;
			o_rsp_valid <= 1'b0;
			o_bus_req_valid <= 1'b0;
			valid_bits <= '0;
			o_hit_count <= '0;
			o_miss_count <= '0;
		end else begin
			o_rsp_valid <= 1'b0;
			case (state)
				CACHE_IDLE: begin
					if (new_req) begin
						if (i_req.flush) begin
							valid_bits <= '0;
							o_rsp_valid <= 1'b1;
						end else if (!i_req.write && hit) begin
							o_rsp_valid <= 1'b1;
							o_hit_count <= o_hit_count + 32'd1;
						end else begin
							o_bus_req_valid <= 1'b1;
							state <= CACHE_BUS;
							if (!i_req.write && cacheable)
								o_miss_count <= o_miss_count + 32'd1;
						end
					end
				end
				default: begin
					if (i_bus_rsp_valid) begin
						o_bus_req_valid <= 1'b0;
						o_rsp_valid <= 1'b1;
						state <= CACHE_IDLE;
						if (cacheable && !i_req.write && !i_bus_rsp.error)
							valid_bits[index] <= 1'b1;
					end
				end
			endcase
		end
	end

	// Lines, tags and response payload
	always_ff @(posedge i_clock) begin
		if (new_req) begin
			o_rsp.rdata <= line_data[index];
			o_rsp.error <= 1'b0;
			o_bus_req.write <= i_req.write;
			o_bus_req.flush <= 1'b0;
			o_bus_req.address <= i_req.address;
			o_bus_req.wdata <= i_req.wdata;
		end
		if (state == CACHE_BUS && i_bus_rsp_valid) begin
			o_rsp <= i_bus_rsp;
			if (cacheable && !i_bus_rsp.error) begin
				if (!i_req.write) begin
					tags[index] <= tag;
					line_data[index] <= i_bus_rsp.rdata;
				end else if (hit) begin
					line_data[index] <= i_req.wdata;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/load_store_unit.sv ====
// Load/store unit
`timescale 1ns/10ps
`default_nettype none

module load_store_unit import lsu_pkg::*; (
	input  logic        i_clock,
	input  logic        i_arst_n,

	// Execute side
	input  logic        i_req_valid,
	input  exec_req_t   i_req,
	output logic        o_req_ready,

	// Writeback side
	output logic        o_result_valid,
	output mem_result_t o_result,

	// Cache side
	output logic        o_cache_req_valid,
	output word_req_t   o_cache_req,
	input  logic        i_cache_rsp_valid,
	input  word_rsp_t   i_cache_rsp
);

	lsu_state_e  state;
	exec_req_t   req_q;
	logic        req_take;
	logic [1:0]  byte_sel;
	logic [7:0]  rd_byte;
	logic [15:0] rd_half;
	logic [31:0] load_value;
	logic [31:0] merged_word;

	assign o_req_ready = (state == ST_IDLE);
	assign req_take = i_req_valid && o_req_ready;

	// ==========================================================================
	// Lane selection
	// ==========================================================================

	assign byte_sel = req_q.address[1:0];
	assign rd_byte = i_cache_rsp.rdata[8*byte_sel +: 8];
	assign rd_half = i_cache_rsp.rdata[16*byte_sel[1] +: 16];

	always_comb begin
		case (req_q.width)
			WIDTH_BYTE: load_value = {{24{req_q.is_signed & rd_byte[7]}}, rd_byte};
			WIDTH_HALF: load_value = {{16{req_q.is_signed & rd_half[15]}}, rd_half};
			default:    load_value = i_cache_rsp.rdata;
		endcase
	end

	// New lanes over the word just read
	always_comb begin
		merged_word = i_cache_rsp.rdata;
		if (req_q.width == WIDTH_BYTE)
			merged_word[8*byte_sel +: 8] = req_q.wdata[7:0];
		else
			merged_word[16*byte_sel[1] +: 16] = req_q.wdata[15:0];
	end

	// ==========================================================================
	// Control
	// ==========================================================================

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
			o_cache_req_valid <= 1'b0;
			o_result_valid <= 1'b0;
		end else begin
			o_result_valid <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (i_req_valid) begin
						case (i_req.op)
							MEM_PASS:  o_result_valid <= 1'b1;
							MEM_LOAD:  state <= ST_READ;
							MEM_FLUSH: state <= ST_FLUSH;
							default:   state <= (i_req.width == WIDTH_WORD) ? ST_WRITE : ST_RMW_READ;
						endcase
						o_cache_req_valid <= (i_req.op != MEM_PASS);
					end
				end
				ST_READ, ST_WRITE, ST_FLUSH: begin
					if (i_cache_rsp_valid) begin
						o_cache_req_valid <= 1'b0;
						o_result_valid <= 1'b1;
						state <= ST_IDLE;
					end
				end
				ST_RMW_READ: begin
					if (i_cache_rsp_valid) begin
						o_cache_req_valid <= 1'b0;
						state <= ST_RMW_WRITE;
					end
				end
				ST_RMW_WRITE: begin
					// Request goes out again one cycle after the read response
					if (i_cache_rsp_valid) begin
						o_cache_req_valid <= 1'b0;
						o_result_valid <= 1'b1;
						state <= ST_IDLE;
					end else begin
						o_cache_req_valid <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ==========================================================================
	// Request and result payload
	// ==========================================================================

	always_ff @(posedge i_clock) begin
		if (req_take) begin
			req_q <= i_req;
			o_cache_req.write <= (i_req.op == MEM_STORE) && (i_req.width == WIDTH_WORD);
			o_cache_req.flush <= (i_req.op == MEM_FLUSH);
			o_cache_req.address <= {i_req.address[31:2], 2'b00};
			o_cache_req.wdata <= i_req.wdata;
			o_result.rd_index <= i_req.rd_index;
			o_result.data <= (i_req.op == MEM_PASS) ? i_req.wdata : '0;
		end
		if (i_cache_rsp_valid && state == ST_READ)
			o_result.data <= load_value;
		if (i_cache_rsp_valid && state == ST_RMW_READ) begin
			o_cache_req.write <= 1'b1;
			o_cache_req.wdata <= merged_word;
		end
	end

endmodule

`default_nettype wire

// ==== design/lsu_pkg.sv ====
// Memory stage types
`default_nettype none

`include "lsu_cfg.svh"

package lsu_pkg;

	// Request kind from execute
	typedef enum logic [1:0] {
		MEM_PASS,
		MEM_LOAD,
		MEM_STORE,
		MEM_FLUSH
	} mem_op_e;

	// Access width
	typedef enum logic [1:0] {
		WIDTH_BYTE,
		WIDTH_HALF,
		WIDTH_WORD
	} mem_width_e;

	// Load/store unit FSM
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ,
		ST_WRITE,
		ST_RMW_READ,
		ST_RMW_WRITE,
		ST_FLUSH
	} lsu_state_e;

	typedef struct packed {
		mem_op_e                 op;
		mem_width_e              width;
		logic                    is_signed;
		logic [31:0]             address;
		logic [`DATA_WIDTH-1:0]  wdata;
		logic [4:0]              rd_index;
	} exec_req_t;

	typedef struct packed {
		logic [4:0]              rd_index;
		logic [`DATA_WIDTH-1:0]  data;
	} mem_result_t;

	// Word-level request, flush only meaningful towards the cache
	typedef struct packed {
		logic                    write;
		logic                    flush;
		logic [31:0]             address;
		logic [`DATA_WIDTH-1:0]  wdata;
	} word_req_t;

	typedef struct packed {
		logic [`DATA_WIDTH-1:0]  rdata;
		logic                    error;
	} word_rsp_t;

endpackage

`default_nettype wire

// ==== design/mem_subsystem_top.sv ====
// Memory subsystem top level
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_top import lsu_pkg::*; (
	input  logic        i_clock,
	input  logic        i_arst_n,

	// Execute and writeback
	input  logic        i_req_valid,
	input  exec_req_t   i_req,
	output logic        o_req_ready,
	output logic        o_result_valid,
	output mem_result_t o_result,

	// Instruction fetch
	input  logic        i_fetch_valid,
	input  logic [31:0] i_fetch_address,
	output logic        o_fetch_rvalid,
	output logic [31:0] o_fetch_rdata,

	// Cache statistics
	output logic [31:0] o_hit_count,
	output logic [31:0] o_miss_count,

	// AXI4-Lite master
	output logic        o_awvalid,
	input  logic        i_awready,
	output logic [31:0] o_awaddr,
	output logic        o_wvalid,
	input  logic        i_wready,
	output logic [31:0] o_wdata,
	output logic [3:0]  o_wstrb,
	input  logic        i_bvalid,
	output logic        o_bready,
	input  logic [1:0]  i_bresp,
	output logic        o_arvalid,
	input  logic        i_arready,
	output logic [31:0] o_araddr,
	input  logic        i_rvalid,
	output logic        o_rready,
	input  logic [31:0] i_rdata,
	input  logic [1:0]  i_rresp
);

	logic      cache_req_valid;
	word_req_t cache_req;
	logic      cache_rsp_valid;
	word_rsp_t cache_rsp;
	logic      dbus_req_valid;
	word_req_t dbus_req;
	logic      dbus_rsp_valid;
	word_rsp_t dbus_rsp;
	logic      bus_req_valid;
	word_req_t bus_req;
	logic      bus_rsp_valid;
	word_rsp_t bus_rsp;

	load_store_unit lsu_i (
		.i_clock          (i_clock),
		.i_arst_n         (i_arst_n),
		.i_req_valid      (i_req_valid),
		.i_req            (i_req),
		.o_req_ready      (o_req_ready),
		.o_result_valid   (o_result_valid),
		.o_result         (o_result),
		.o_cache_req_valid(cache_req_valid),
		.o_cache_req      (cache_req),
		.i_cache_rsp_valid(cache_rsp_valid),
		.i_cache_rsp      (cache_rsp)
	);

	dcache_wt dcache_i (
		.i_clock        (i_clock),
		.i_arst_n       (i_arst_n),
		.i_req_valid    (cache_req_valid),
		.i_req          (cache_req),
		.o_rsp_valid    (cache_rsp_valid),
		.o_rsp          (cache_rsp),
		.o_bus_req_valid(dbus_req_valid),
		.o_bus_req      (dbus_req),
		.i_bus_rsp_valid(dbus_rsp_valid),
		.i_bus_rsp      (dbus_rsp),
		.o_hit_count    (o_hit_count),
		.o_miss_count   (o_miss_count)
	);

	bus_arbiter arbiter_i (
		.i_clock          (i_clock),
		.i_arst_n         (i_arst_n),
		.i_data_req_valid (dbus_req_valid),
		.i_data_req       (dbus_req),
		.o_data_rsp_valid (dbus_rsp_valid),
		.o_data_rsp       (dbus_rsp),
		.i_fetch_req_valid(i_fetch_valid),
		.i_fetch_address  (i_fetch_address),
		.o_fetch_rsp_valid(o_fetch_rvalid),
		.o_fetch_rdata    (o_fetch_rdata),
		.o_bus_req_valid  (bus_req_valid),
		.o_bus_req        (bus_req),
		.i_bus_rsp_valid  (bus_rsp_valid),
		.i_bus_rsp        (bus_rsp)
	);

	axil_master axil_i (
		.i_clock    (i_clock),
		.i_arst_n   (i_arst_n),
		.i_req_valid(bus_req_valid),
		.i_req      (bus_req),
		.o_rsp_valid(bus_rsp_valid),
		.o_rsp      (bus_rsp),
		.o_awvalid  (o_awvalid),
		.i_awready  (i_awready),
		.o_awaddr   (o_awaddr),
		.o_wvalid   (o_wvalid),
		.i_wready   (i_wready),
		.o_wdata    (o_wdata),
		.o_wstrb    (o_wstrb),
		.i_bvalid   (i_bvalid),
		.o_bready   (o_bready),
		.i_bresp    (i_bresp),
		.o_arvalid  (o_arvalid),
		.i_arready  (i_arready),
		.o_araddr   (o_araddr),
		.i_rvalid   (i_rvalid),
		.o_rready   (o_rready),
		.i_rdata    (i_rdata),
		.i_rresp    (i_rresp)
	);

endmodule

`default_nettype wire

// ==== include/lsu_cfg.svh ====
// Memory subsystem configuration
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// ==========================================================================
// Data cache geometry
// ==========================================================================

// Log2 of the number of one-word lines
`define DCACHE_INDEX_BITS 4

// Address bits 31:28 of cacheable space
`define CACHEABLE_REGION 4'h1

// Width of data words on every link
`define DATA_WIDTH 32

// Testbench watchdog budget, in cycles per operation
`define WATCHDOG_CYCLES_PER_OP 64

`endif

// ==== list.f ====
+incdir+include
design/lsu_pkg.sv
design/load_store_unit.sv
design/dcache_wt.sv
design/bus_arbiter.sv
design/axil_master.sv
design/mem_subsystem_top.sv
testbench/mem_subsystem_properties.sv
testbench/tb_mem_subsystem.sv

// ==== testbench/mem_subsystem_properties.sv ====
// Memory subsystem handshake assertions
`timescale 1ns/10ps
`default_nettype none

module mem_subsystem_properties import lsu_pkg::*; (
	input wire logic        i_clock,
	input wire logic        i_arst_n,
	input wire logic        o_awvalid,
	input wire logic        i_awready,
	input wire logic [31:0] o_awaddr,
	input wire logic        o_wvalid,
	input wire logic        i_wready,
	input wire logic [31:0] o_wdata,
	input wire logic        o_arvalid,
	input wire logic        i_arready,
	input wire logic [31:0] o_araddr,
	input wire logic        o_result_valid,
	input wire logic        o_req_ready,
	input wire logic        cache_req_valid,
	input wire logic        dbus_rsp_valid,
	input wire logic        o_fetch_rvalid
);

	// ==========================================================================
	// AXI channels hold until accepted
	// ==========================================================================

	aw_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		o_awvalid && !i_awready |=> o_awvalid && $stable(o_awaddr))
		else $error("AW valid or address changed before awready");

	w_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		o_wvalid && !i_wready |=> o_wvalid && $stable(o_wdata))
		else $error("W valid or data changed before wready");

	ar_held: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		o_arvalid && !i_arready |=> o_arvalid && $stable(o_araddr))
		else $error("AR valid or address changed before arready");

	// Pipeline side
	result_pulse: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		o_result_valid |=> !o_result_valid)
		else $error("Result valid lasted two cycles");

	busy_not_ready: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		cache_req_valid |-> !o_req_ready)
		else $error("Request ready while a cache request is in flight");

	one_response: assert property (@(posedge i_clock) disable iff (!i_arst_n)
		!(dbus_rsp_valid && o_fetch_rvalid))
		else $error("Arbiter answered both requesters in one cycle");

endmodule

bind mem_subsystem_top mem_subsystem_properties props_i (.*);

`default_nettype wire

// ==== testbench/tb_mem_subsystem.sv ====
// Memory subsystem testbench
`timescale 1ns/10ps
`default_nettype none

`include "lsu_cfg.svh"

module tb_mem_subsystem import lsu_pkg::*; ();

	// Upper bound on data operations and fetches over all tests
	localparam int OP_BUDGET = 160;

	logic        i_clock;
	logic        i_arst_n;
	logic        i_req_valid;
	exec_req_t   i_req;
	logic        o_req_ready;
	logic        o_result_valid;
	mem_result_t o_result;
	logic        i_fetch_valid;
	logic [31:0] i_fetch_address;
	logic        o_fetch_rvalid;
	logic [31:0] o_fetch_rdata;
	logic [31:0] o_hit_count;
	logic [31:0] o_miss_count;
	logic        o_awvalid;
	logic        i_awready;
	logic        o_wvalid;
	logic        i_wready;
	logic        i_bvalid;
	logic        o_bready;
	logic        o_arvalid;
	logic        i_arready;
	logic        i_rvalid;
	logic        o_rready;
	logic [31:0] o_awaddr;
	logic [31:0] o_wdata;
	logic [31:0] o_araddr;
	logic [31:0] i_rdata;
	logic [3:0]  o_wstrb;
	logic [1:0]  i_bresp;
	logic [1:0]  i_rresp;

	// Word-addressed memories
	// Unwritten words read as the fill pattern
	logic [31:0] model_mem [logic [31:0]];
	logic [31:0] ref_mem [logic [31:0]];

	mem_subsystem_top dut_i (.*);

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	// ==========================================================================
	// Checking and reference helpers
	// ==========================================================================

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s is 0x%h, expected 0x%h", name, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h6B2D_93E5;
	endfunction

	function automatic logic [31:0] model_word(input logic [31:0] addr);
		logic [31:0] key;
		key = {addr[31:2], 2'b00};
		return model_mem.exists(key) ? model_mem[key] : fill_word(key);
	endfunction

	function automatic logic [31:0] ref_word(input logic [31:0] addr);
		logic [31:0] key;
		key = {addr[31:2], 2'b00};
		return ref_mem.exists(key) ? ref_mem[key] : fill_word(key);
	endfunction

	// RISC-V load semantics on a little-endian word
	function automatic logic [31:0] expected_load(input logic [31:0] word,
			input mem_width_e width, input logic sgn, input logic [1:0] off);
		logic [31:0] shifted;
		shifted = word >> (8 * int'(off));
		case (width)
			WIDTH_BYTE: return sgn ? {{24{shifted[7]}}, shifted[7:0]} : {24'h0, shifted[7:0]};
			WIDTH_HALF: return sgn ? {{16{shifted[15]}}, shifted[15:0]} : {16'h0, shifted[15:0]};
			default:    return word;
		endcase
	endfunction

	function automatic logic [31:0] merge_store(input logic [31:0] word,
			input mem_width_e width, input logic [1:0] off, input logic [31:0] data);
		logic [31:0] mask;
		int sh;
		sh = 8 * int'(off);
		case (width)
			WIDTH_BYTE: mask = 32'h0000_00FF;
			WIDTH_HALF: mask = 32'h0000_FFFF;
			default:    mask = 32'hFFFF_FFFF;
		endcase
		mask = mask << sh;
		return (word & ~mask) | ((data << sh) & mask);
	endfunction

	// ==========================================================================
	// AXI4-Lite slave model
	// ==========================================================================

	initial begin : read_slave
		logic [31:0] addr;
		forever begin
			@(posedge i_clock);
			#1;
			if (o_arvalid) begin
				addr = o_araddr;
				repeat ($urandom % 4) begin
					@(posedge i_clock);
					#1;
				end
				i_arready = 1'b1;
				@(posedge i_clock);
				#1;
				i_arready = 1'b0;
				repeat ($urandom % 4) begin
					@(posedge i_clock);
					#1;
				end
				i_rvalid = 1'b1;
				i_rdata = model_word(addr);
				i_rresp = 2'b00;
				@(posedge i_clock);
				#1;
				i_rvalid = 1'b0;
			end
		end
	end

	initial begin : write_slave
		logic [31:0] addr;
		logic [31:0] data;
		int aw_wait;
		int w_wait;
		int n;
		logic aw_done;
		logic w_done;
		forever begin
			@(posedge i_clock);
			#1;
			if (o_awvalid) begin
				addr = o_awaddr;
				data = o_wdata;
				check_value("o_wstrb", {28'h0, o_wstrb}, 32'hF);
				aw_wait = $urandom % 4;
				w_wait = $urandom % 4;
				aw_done = 1'b0;
				w_done = 1'b0;
				n = 0;
				// AW and W accepted on their own delays
				while (!(aw_done && w_done)) begin
					i_awready = !aw_done && (n >= aw_wait);
					i_wready = !w_done && (n >= w_wait);
					@(posedge i_clock);
					#1;
					if (i_awready)
						aw_done = 1'b1;
					if (i_wready)
						w_done = 1'b1;
					i_awready = 1'b0;
					i_wready = 1'b0;
					n++;
				end
				model_mem[{addr[31:2], 2'b00}] = data;
				repeat ($urandom % 4) begin
					@(posedge i_clock);
					#1;
				end
				i_bvalid = 1'b1;
				i_bresp = 2'b00;
				@(posedge i_clock);
				#1;
				i_bvalid = 1'b0;
			end
		end
	end

	// ==========================================================================
	// Request tasks
	// ==========================================================================

	task automatic run_op(input mem_op_e op, input mem_width_e width, input logic sgn,
			input logic [31:0] addr, input logic [31:0] wdata, input logic [4:0] rd,
			output logic [31:0] data, output int latency);
		exec_req_t req;
		while (!o_req_ready) begin
			@(posedge i_clock);
			#1;
		end
		req.op = op;
		req.width = width;
		req.is_signed = sgn;
		req.address = addr;
		req.wdata = wdata;
		req.rd_index = rd;
		i_req = req;
		i_req_valid = 1'b1;
		@(posedge i_clock);
		#1;
		i_req_valid = 1'b0;
		latency = 1;
		while (!o_result_valid) begin
			@(posedge i_clock);
			#1;
			latency++;
		end
		check_value("o_result.rd_index", {27'h0, o_result.rd_index}, {27'h0, rd});
		data = o_result.data;
	endtask

	task automatic store_and_track(input mem_width_e width, input logic [31:0] addr,
			input logic [31:0] data);
		logic [31:0] result;
		int lat;
		ref_mem[{addr[31:2], 2'b00}] = merge_store(ref_word(addr), width, addr[1:0], data);
		run_op(MEM_STORE, width, 1'b0, addr, data, 5'd3, result, lat);
		check_value("o_result.data", result, 32'h0);
	endtask

	task automatic verify_load(input mem_width_e width, input logic sgn,
			input logic [31:0] addr, output int lat);
		logic [31:0] result;
		logic [31:0] expected;
		expected = expected_load(ref_word(addr), width, sgn, addr[1:0]);
		run_op(MEM_LOAD, width, sgn, addr, 32'h0, 5'd9, result, lat);
		check_value("o_result.data", result, expected);
	endtask

	task automatic load_all_lanes(input logic [31:0] base);
		int lat;
		for (int off = 0; off < 4; off++) begin
			verify_load(WIDTH_BYTE, 1'b1, base + off, lat);
			verify_load(WIDTH_BYTE, 1'b0, base + off, lat);
		end
		for (int off = 0; off < 4; off += 2) begin
			verify_load(WIDTH_HALF, 1'b1, base + off, lat);
			verify_load(WIDTH_HALF, 1'b0, base + off, lat);
		end
	endtask

	// ==========================================================================
	// Directed tests
	// ==========================================================================

	task automatic reset_and_pass();
		logic [31:0] d;
		logic [31:0] value;
		int lat;
		check_value("o_req_ready", {31'h0, o_req_ready}, 32'h1);
		check_value("o_result_valid", {31'h0, o_result_valid}, 32'h0);
		check_value("o_fetch_rvalid", {31'h0, o_fetch_rvalid}, 32'h0);
		check_value("o_awvalid", {31'h0, o_awvalid}, 32'h0);
		check_value("o_wvalid", {31'h0, o_wvalid}, 32'h0);
		check_value("o_arvalid", {31'h0, o_arvalid}, 32'h0);
		check_value("o_bready", {31'h0, o_bready}, 32'h1);
		check_value("o_rready", {31'h0, o_rready}, 32'h1);
		check_value("o_hit_count", o_hit_count, 32'h0);
		check_value("o_miss_count", o_miss_count, 32'h0);
		value = $urandom;
		run_op(MEM_PASS, WIDTH_WORD, 1'b0, 32'h0, value, 5'd7, d, lat);
		check_value("o_result.data", d, value);
		check_value("pass latency", lat, 32'd1);
	endtask

	task automatic uncached_words();
		int lat;
		for (int i = 0; i < 4; i++)
			store_and_track(WIDTH_WORD, 32'h2000_0100 + 4 * i, $urandom);
		for (int i = 0; i < 4; i++) begin
			verify_load(WIDTH_WORD, 1'b0, 32'h2000_0100 + 4 * i, lat);
			check_value("model memory", model_word(32'h2000_0100 + 4 * i),
				ref_word(32'h2000_0100 + 4 * i));
		end
	endtask

	task automatic sub_word_lanes();
		logic [31:0] base;
		logic [31:0] r;
		int lat;
		base = 32'h2000_0200;
		store_and_track(WIDTH_WORD, base, 32'h8081_7F90);
		load_all_lanes(base);
		for (int off = 0; off < 4; off++) begin
			r = $urandom;
			store_and_track(WIDTH_BYTE, base + off, {24'h0, 1'b1, r[6:0]});
			verify_load(WIDTH_WORD, 1'b0, base, lat);
		end
		for (int off = 0; off < 4; off += 2) begin
			r = $urandom;
			store_and_track(WIDTH_HALF, base + off, {16'h0, 1'b1, r[14:0]});
			verify_load(WIDTH_WORD, 1'b0, base, lat);
		end
		load_all_lanes(base);
		check_value("model memory", model_word(base), ref_word(base));
	endtask

	task automatic cache_hit_miss();
		logic [31:0] addr;
		logic [31:0] hits;
		logic [31:0] misses;
		int lat;
		addr = 32'h1000_0040;
		hits = o_hit_count;
		misses = o_miss_count;
		verify_load(WIDTH_WORD, 1'b0, addr, lat);
		check_value("o_miss_count", o_miss_count, misses + 1);
		check_value("o_hit_count", o_hit_count, hits);
		verify_load(WIDTH_WORD, 1'b0, addr, lat);
		check_value("hit latency", lat, 32'd3);
		check_value("o_hit_count", o_hit_count, hits + 1);
		store_and_track(WIDTH_WORD, addr, $urandom);
		check_value("model memory", model_word(addr), ref_word(addr));
		verify_load(WIDTH_WORD, 1'b0, addr, lat);
		check_value("hit latency", lat, 32'd3);
		check_value("o_hit_count", o_hit_count, hits + 2);
		check_value("o_miss_count", o_miss_count, misses + 1);
	endtask

	task automatic flush_and_reload();
		logic [31:0] d;
		logic [31:0] misses;
		int lat;
		run_op(MEM_FLUSH, WIDTH_WORD, 1'b0, 32'h1000_0040, 32'h0, 5'd4, d, lat);
		check_value("o_result.data", d, 32'h0);
		misses = o_miss_count;
		verify_load(WIDTH_WORD, 1'b0, 32'h1000_0040, lat);
		check_value("o_miss_count", o_miss_count, misses + 1);
	endtask

	task automatic fetch_stream(input int count);
		logic [31:0] addr;
		for (int i = 0; i < count; i++) begin
			addr = 32'h0000_0400 + 4 * ($urandom % 64);
			i_fetch_address = addr;
			i_fetch_valid = 1'b1;
			do begin
				@(posedge i_clock);
				#1;
			end while (!o_fetch_rvalid);
			check_value("o_fetch_rdata", o_fetch_rdata, model_word(addr));
			i_fetch_valid = 1'b0;
			repeat ($urandom % 3) begin
				@(posedge i_clock);
				#1;
			end
		end
	endtask

	task automatic data_stream(input int count);
		logic [31:0] r;
		logic [31:0] addr;
		mem_width_e width;
		int lat;
		for (int i = 0; i < count; i++) begin
			r = $urandom;
			width = mem_width_e'(2'(r % 3));
			addr = {r[4] ? 4'h1 : 4'h2, 28'h000_0300} | {26'h0, r[19:16], 2'b00};
			if (width == WIDTH_BYTE)
				addr[1:0] = r[11:10];
			else if (width == WIDTH_HALF)
				addr[1] = r[11];
			if (r[12])
				store_and_track(width, addr, $urandom);
			else
				verify_load(width, r[13], addr, lat);
		end
	endtask

	task automatic concurrent_traffic();
		fork
			fetch_stream(24);
			data_stream(48);
		join
	endtask

	// ==========================================================================
	// Run control
	// ==========================================================================

	initial begin : watchdog
		repeat (OP_BUDGET * `WATCHDOG_CYCLES_PER_OP) @(posedge i_clock);
		$display("Watchdog expired: the tests did not finish in time");
		$display("TEST FAILED");
		$fatal(1);
	end

	initial begin
		void'($urandom(81));
		i_arst_n = 1'b0;
		i_req_valid = 1'b0;
		i_req = '0;
		i_fetch_valid = 1'b0;
		i_fetch_address = 32'h0;
		i_awready = 1'b0;
		i_wready = 1'b0;
		i_bvalid = 1'b0;
		i_bresp = 2'b00;
		i_arready = 1'b0;
		i_rvalid = 1'b0;
		i_rdata = 32'h0;
		i_rresp = 2'b00;
		repeat (4) @(posedge i_clock);
		#1;
		i_arst_n = 1'b1;
		reset_and_pass();
		uncached_words();
		sub_word_lanes();
		cache_hit_miss();
		flush_and_reload();
		concurrent_traffic();
		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire
